// File: filelist.f
+incdir+hdl
hdl/core_pkg.sv
hdl/instr_wb_if.sv
hdl/prog_mem.sv
hdl/fetch_unit.sv
hdl/instr_queue.sv
hdl/reg_file.sv
hdl/exec_unit.sv
hdl/core_top.sv
testbench/core_tb.sv

// File: hdl/core_cfg.svh
`ifndef CORE_CFG_SVH
`define CORE_CFG_SVH

// Instruction and data word width
`define CORE_WORD_W 24

// Program address width
`define CORE_ADDR_W 8

// Instruction memory size in words
`define CORE_MEM_WORDS (1 << `CORE_ADDR_W)

// General register count
`define CORE_REG_CNT 16

// Instruction queue entries
`define CORE_QUEUE_DEPTH 4

`endif

// File: hdl/core_pkg.sv
`default_nettype none

`include "core_cfg.svh"

package core_pkg;

    typedef logic [`CORE_WORD_W-1:0] word_t;

    typedef logic [`CORE_ADDR_W-1:0] pc_t;

    typedef logic [$clog2(`CORE_REG_CNT)-1:0] reg_idx_t;

    // Opcode lives in bits 23..20 of the instruction
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_MOVI = 4'd1,
        OP_ADD  = 4'd2,
        OP_SUB  = 4'd3,
        OP_AND  = 4'd4,
        OP_OR   = 4'd5,
        OP_XOR  = 4'd6,
        OP_BNZ  = 4'd7,
        OP_HALT = 4'd15
    } opcode_e;

    // One fetched instruction with the address it came from
    typedef struct packed {
        pc_t   pc;
        word_t instr;
    } fetch_item_t;

endpackage

`default_nettype wire

// File: hdl/core_top.sv
`default_nettype none

module core_top
    import core_pkg::*;
(
    input  wire        iw_clk,
    input  wire        iw_rst,
    input  wire        run,
    input  wire        prog_cyc,
    input  wire        prog_stb,
    input  wire        prog_we,
    input  wire pc_t   prog_adr,
    input  wire word_t prog_dat,
    output logic       prog_ack,
    output logic       retire_valid,
    output reg_idx_t   retire_reg,
    output word_t      retire_data,
    output logic       halted
);

    pc_t   rd_addr;
    word_t rd_data;
    logic  redirect_valid;
    pc_t   redirect_pc;

    instr_wb_if push_if ();
    instr_wb_if pop_if ();

    prog_mem prog_mem_inst (
        .iw_clk  (iw_clk),
        .prog_cyc(prog_cyc),
        .prog_stb(prog_stb),
        .prog_we (prog_we),
        .prog_adr(prog_adr),
        .prog_dat(prog_dat),
        .prog_ack(prog_ack),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    fetch_unit fetch_unit_inst (
        .iw_clk        (iw_clk),
        .iw_rst        (iw_rst),
        .run           (run),
        .redirect_valid(redirect_valid),
        .redirect_pc   (redirect_pc),
        .rd_addr       (rd_addr),
        .rd_data       (rd_data),
        .push          (push_if.master)
    );

    // A taken branch also empties the queue
    instr_queue instr_queue_inst (
        .iw_clk(iw_clk),
        .iw_rst(iw_rst),
        .flush (redirect_valid),
        .push  (push_if.slave),
        .pop   (pop_if.slave)
    );

    exec_unit exec_unit_inst (
        .iw_clk        (iw_clk),
        .iw_rst        (iw_rst),
        .pop           (pop_if.master),
        .redirect_valid(redirect_valid),
        .redirect_pc   (redirect_pc),
        .retire_valid  (retire_valid),
        .retire_reg    (retire_reg),
        .retire_data   (retire_data),
        .halted        (halted)
    );

endmodule

`default_nettype wire

// File: hdl/exec_unit.sv
`default_nettype none

module exec_unit
    import core_pkg::*;
(
    input  wire        iw_clk,
    input  wire        iw_rst,
    instr_wb_if.master pop,
    output logic       redirect_valid,
    output pc_t        redirect_pc,
    output logic       retire_valid,
    output reg_idx_t   retire_reg,
    output word_t      retire_data,
    output logic       halted
);

    word_t    instr;
    opcode_e  op;
    reg_idx_t rd;
    reg_idx_t rs;
    reg_idx_t rt;
    word_t    src_a;
    word_t    src_b;
    word_t    result;
    logic     take;
    logic     writes;
    logic     branch;
    logic     halt_now;
    logic     stb_q;

    assign take  = pop.cyc && pop.stb && pop.ack;
    assign instr = pop.dat_r.instr;
    assign op    = opcode_e'(instr[23:20]);
    assign rd    = instr[19:16];
    assign rs    = instr[15:12];
    assign rt    = instr[11:8];

    reg_file reg_file_inst (
        .iw_clk   (iw_clk),
        .iw_rst   (iw_rst),
        .rd_idx_a (rs),
        .rd_idx_b (rt),
        .rd_data_a(src_a),
        .rd_data_b(src_b),
        .wr_idx   (rd),
        .wr_en    (take && writes),
        .wr_data  (result)
    );

    // Unlisted opcodes fall to the default and do nothing
    always_comb begin
        result   = '0;
        writes   = 1'b0;
        branch   = 1'b0;
        halt_now = 1'b0;
        case (op)
            OP_MOVI: begin
                result = word_t'(instr[11:0]);
                writes = 1'b1;
            end
            OP_ADD: begin
                result = src_a + src_b;
                writes = 1'b1;
            end
            OP_SUB: begin
                result = src_a - src_b;
                writes = 1'b1;
            end
            OP_AND: begin
                result = src_a & src_b;
                writes = 1'b1;
            end
            OP_OR: begin
                result = src_a | src_b;
                writes = 1'b1;
            end
            OP_XOR: begin
                result = src_a ^ src_b;
                writes = 1'b1;
            end
            // BNZ tests rs
            OP_BNZ:  branch = (src_a != '0);
            OP_HALT: halt_now = 1'b1;
            default: ;
        endcase
    end

    // Request stays up; the queue acks every other cycle at most
    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            stb_q          <= 1'b0;
            retire_valid   <= 1'b0;
            redirect_valid <= 1'b0;
            halted         <= 1'b0;
        end else begin
            stb_q          <= !(halted || (take && halt_now));
            retire_valid   <= take && writes;
            redirect_valid <= take && branch;
            if (take && halt_now) begin
                halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge iw_clk) begin
        if (take && writes) begin
            retire_reg  <= rd;
            retire_data <= result;
        end
        if (take && branch) begin
            redirect_pc <= pc_t'(instr[7:0]);
        end
    end

    assign pop.cyc   = stb_q;
    assign pop.stb   = stb_q;
    assign pop.we    = 1'b0;
    assign pop.dat_w = '0;

endmodule

`default_nettype wire

// File: hdl/fetch_unit.sv
`default_nettype none

module fetch_unit
    import core_pkg::*;
(
    input  wire          iw_clk,
    input  wire          iw_rst,
    input  wire          run,
    input  wire          redirect_valid,
    input  wire pc_t     redirect_pc,
    output pc_t          rd_addr,
    input  wire word_t   rd_data,
    instr_wb_if.master   push
);

    typedef enum logic [1:0] {
        S_READ,
        S_DATA,
        S_PUSH
    } state_t;

    state_t      state;
    pc_t         pc;
    pc_t         pc_inc;
    logic        stb_q;
    logic        push_done;
    fetch_item_t item;

    assign pc_inc    = pc + pc_t'(1);
    assign push_done = (state == S_PUSH) && push.ack;

    // The ack cycle doubles as the read of the next word
    assign rd_addr = (push_done && run) ? pc_inc : pc;

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            state <= S_READ;
            pc    <= '0;
            stb_q <= 1'b0;
        end else if (redirect_valid) begin
            // Drop the held item and restart at the target
            state <= S_READ;
            pc    <= redirect_pc;
            stb_q <= 1'b0;
        end else begin
            case (state)
                S_READ: begin
                    if (run) begin
                        state <= S_DATA;
                    end
                end
                S_DATA: begin
                    state <= S_PUSH;
                    stb_q <= 1'b1;
                end
                S_PUSH: begin
                    if (push.ack) begin
                        stb_q <= 1'b0;
                        pc    <= pc_inc;
                        state <= run ? S_DATA : S_READ;
                    end
                end
                default: state <= S_READ;
            endcase
        end
    end

    always_ff @(posedge iw_clk) begin
        if (state == S_DATA) begin
            item.pc    <= pc;
            item.instr <= rd_data;
        end
    end

    assign push.cyc   = stb_q;
    assign push.stb   = stb_q;
    assign push.we    = 1'b1;
    assign push.dat_w = item;

endmodule

`default_nettype wire

// File: hdl/instr_queue.sv
`default_nettype none

`include "core_cfg.svh"

module instr_queue
    import core_pkg::*;
#(
    parameter int DEPTH = `CORE_QUEUE_DEPTH
) (
    input  wire        iw_clk,
    input  wire        iw_rst,
    input  wire        flush,
    instr_wb_if.slave  push,
    instr_wb_if.slave  pop
);

    localparam int PTR_W = $clog2(DEPTH);
    localparam logic [PTR_W-1:0] PTR_ONE = 1;
    localparam logic [PTR_W:0]   CNT_ONE = 1;

    fetch_item_t      mem [DEPTH];
    fetch_item_t      pop_data;
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W:0]   count;
    logic             push_ack;
    logic             pop_ack;
    logic             full;
    logic             empty;
    logic             push_fire;
    logic             pop_fire;

    // Count reaches DEPTH only with its top bit set
    assign full  = count[PTR_W];
    assign empty = (count == '0);

    // Registered acks; a raised ack blocks a repeat on the same strobe
    assign push_fire = push.cyc && push.stb && push.we && !push_ack && !full && !flush;
    assign pop_fire  = pop.cyc && pop.stb && !pop.we && !pop_ack && !empty && !flush;

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            push_ack <= 1'b0;
            pop_ack  <= 1'b0;
        end else if (flush) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            push_ack <= 1'b0;
            pop_ack  <= 1'b0;
        end else begin
            push_ack <= push_fire;
            pop_ack  <= pop_fire;
            if (push_fire) begin
                wr_ptr <= wr_ptr + PTR_ONE;
            end
            if (pop_fire) begin
                rd_ptr <= rd_ptr + PTR_ONE;
            end
            case ({push_fire, pop_fire})
                2'b10:   count <= count + CNT_ONE;
                2'b01:   count <= count - CNT_ONE;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge iw_clk) begin
        if (push_fire) begin
            mem[wr_ptr] <= push.dat_w;
        end
        if (pop_fire) begin
            pop_data <= mem[rd_ptr];
        end
    end

    assign push.ack   = push_ack;
    assign push.dat_r = '0;
    assign pop.ack    = pop_ack;
    assign pop.dat_r  = pop_data;

endmodule

`default_nettype wire

// File: hdl/instr_wb_if.sv
`default_nettype none

interface instr_wb_if
    import core_pkg::*;
();

    logic        cyc;
    logic        stb;
    logic        we;
    logic        ack;
    fetch_item_t dat_w;
    fetch_item_t dat_r;

    modport master (
        output cyc, stb, we, dat_w,
        input  ack, dat_r
    );

    modport slave (
        input  cyc, stb, we, dat_w,
        output ack, dat_r
    );

endinterface

`default_nettype wire

// File: hdl/prog_mem.sv
`default_nettype none

`include "core_cfg.svh"

module prog_mem
    import core_pkg::*;
(
    input  wire        iw_clk,
    input  wire        prog_cyc,
    input  wire        prog_stb,
    input  wire        prog_we,
    input  wire pc_t   prog_adr,
    input  wire word_t prog_dat,
    output logic       prog_ack,
    input  wire pc_t   rd_addr,
    output word_t      rd_data
);

    word_t mem [`CORE_MEM_WORDS];

    logic wr_req;

    // A held strobe is taken once; ack blocks a second write
    assign wr_req = prog_cyc && prog_stb && prog_we && !prog_ack;

    always_ff @(posedge iw_clk) begin
        prog_ack <= wr_req;
    end

    always_ff @(posedge iw_clk) begin
        if (wr_req) begin
            mem[prog_adr] <= prog_dat;
        end
    end

    // Fetch read port, data one cycle after address
    always_ff @(posedge iw_clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// File: hdl/reg_file.sv
`default_nettype none

`include "core_cfg.svh"

module reg_file
    import core_pkg::*;
(
    input  wire           iw_clk,
    input  wire           iw_rst,
    input  wire reg_idx_t rd_idx_a,
    input  wire reg_idx_t rd_idx_b,
    output word_t         rd_data_a,
    output word_t         rd_data_b,
    input  wire reg_idx_t wr_idx,
    input  wire           wr_en,
    input  wire word_t    wr_data
);

    word_t regs [`CORE_REG_CNT];

    always_ff @(posedge iw_clk or posedge iw_rst) begin
        if (iw_rst) begin
            for (int i = 0; i < `CORE_REG_CNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr_idx] <= wr_data;
        end
    end

    // Combinational reads see a write one cycle after it is issued
    assign rd_data_a = regs[rd_idx_a];
    assign rd_data_b = regs[rd_idx_b];

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module core_tb \
    -f filelist.f \
    -o core_sim

./obj_dir/core_sim

// File: testbench/core_tb.sv
`default_nettype none

`include "core_cfg.svh"

module core_tb
    import core_pkg::*;
();

    localparam int NUM_TESTS       = 5;
    localparam int CYCLES_PER_TEST = 200;
    localparam int BP_WORDS        = 5 * `CORE_QUEUE_DEPTH;

    logic     iw_clk;
    logic     iw_rst;
    logic     run;
    logic     prog_cyc;
    logic     prog_stb;
    logic     prog_we;
    pc_t      prog_adr;
    word_t    prog_dat;
    logic     prog_ack;
    logic     retire_valid;
    reg_idx_t retire_reg;
    word_t    retire_data;
    logic     halted;

    // Copy of every word written into program memory
    word_t       image [`CORE_MEM_WORDS];
    word_t       prog_q [$];
    logic [31:0] exp_q [$];
    logic [31:0] got_q [$];
    logic [31:0] lcg_state;

    core_top core_top_inst (
        .iw_clk      (iw_clk),
        .iw_rst      (iw_rst),
        .run         (run),
        .prog_cyc    (prog_cyc),
        .prog_stb    (prog_stb),
        .prog_we     (prog_we),
        .prog_adr    (prog_adr),
        .prog_dat    (prog_dat),
        .prog_ack    (prog_ack),
        .retire_valid(retire_valid),
        .retire_reg  (retire_reg),
        .retire_data (retire_data),
        .halted      (halted)
    );

    initial begin
        iw_clk = 1'b0;
        forever #5 iw_clk = ~iw_clk;
    end

    // Retire port sampled mid-cycle
    always @(negedge iw_clk) begin
        if (retire_valid === 1'b1) begin
            got_q.push_back({4'h0, retire_reg, retire_data});
        end
    end

    initial begin
        repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge iw_clk);
        fail_run("timeout: the tests did not finish within the cycle budget");
    end

    function automatic logic [11:0] next_operand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[27:16];
    endfunction

    // Low field is imm12, or rt in its top nibble, or the branch target
    function automatic word_t encode(input logic [3:0] op, input logic [3:0] rd,
                                     input logic [3:0] rs, input logic [11:0] low);
        return {op, rd, rs, low};
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        fail_run($sformatf("mismatch in %s: expected %h, actual %h", name, expected, actual));
    endtask

    // The previous test leaves halted set, so this also proves the reset clears it
    task automatic begin_test();
        @(posedge iw_clk);
        iw_rst <= 1'b1;
        run    <= 1'b0;
        repeat (5) @(posedge iw_clk);
        iw_rst <= 1'b0;
        prog_q.delete();
        @(negedge iw_clk);
        assert (retire_valid === 1'b0 && halted === 1'b0 && prog_ack === 1'b0)
            else fail_run("control outputs active after reset");
    endtask

    task automatic load_word(input pc_t adr, input word_t dat);
        @(posedge iw_clk);
        prog_cyc <= 1'b1;
        prog_stb <= 1'b1;
        prog_we  <= 1'b1;
        prog_adr <= adr;
        prog_dat <= dat;
        @(negedge iw_clk);
        assert (prog_ack === 1'b0) else fail_run("program port acked in the strobe cycle");
        @(negedge iw_clk);
        assert (prog_ack === 1'b1) else fail_run("program port gave no ack after the strobe");
        @(posedge iw_clk);
        prog_cyc <= 1'b0;
        prog_stb <= 1'b0;
        prog_we  <= 1'b0;
        @(negedge iw_clk);
        assert (prog_ack === 1'b0) else fail_run("program port acked one write twice");
        image[adr] = dat;
    endtask

    task automatic load_program();
        for (int i = 0; i < prog_q.size(); i++) begin
            load_word(pc_t'(i), prog_q[i]);
        end
    endtask

    // Interprets the memory image from address 0 up to HALT
    task automatic build_expected();
        word_t      regs [`CORE_REG_CNT];
        word_t      ins;
        word_t      a;
        word_t      b;
        word_t      res;
        pc_t        pc;
        pc_t        nxt;
        logic [3:0] op;
        logic       wr;
        logic       done;
        int         steps;
        for (int i = 0; i < `CORE_REG_CNT; i++) begin
            regs[i] = '0;
        end
        exp_q.delete();
        pc    = '0;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < 1000) begin
            ins = image[pc];
            op  = ins[23:20];
            a   = regs[ins[15:12]];
            b   = regs[ins[11:8]];
            res = '0;
            wr  = 1'b1;
            nxt = pc + 8'd1;
            case (op)
                OP_MOVI: res = {12'h000, ins[11:0]};
                OP_ADD:  res = a + b;
                OP_SUB:  res = a - b;
                OP_AND:  res = a & b;
                OP_OR:   res = a | b;
                OP_XOR:  res = a ^ b;
                OP_BNZ: begin
                    wr = 1'b0;
                    if (a != '0) begin
                        nxt = ins[7:0];
                    end
                end
                OP_HALT: begin
                    wr   = 1'b0;
                    done = 1'b1;
                end
                default: wr = 1'b0;
            endcase
            if (wr) begin
                regs[ins[19:16]] = res;
                exp_q.push_back({4'h0, ins[19:16], res});
            end
            pc    = nxt;
            steps = steps + 1;
        end
        assert (done) else fail_run("reference model never reached HALT");
    endtask

    task automatic run_program(input string name, input int settle);
        int n_halt;
        build_expected();
        got_q.delete();
        @(posedge iw_clk);
        run <= 1'b1;
        @(negedge iw_clk);
        while (halted !== 1'b1) begin
            @(negedge iw_clk);
        end
        @(posedge iw_clk);
        n_halt = got_q.size();
        repeat (settle) @(posedge iw_clk);
        assert (got_q.size() == n_halt) else fail_run({name, ": retire after halt"});
        assert (got_q.size() == exp_q.size())
            else report_mismatch(name, exp_q.size(), got_q.size());
        for (int i = 0; i < exp_q.size(); i++) begin
            assert (got_q[i] == exp_q[i]) else report_mismatch(name, exp_q[i], got_q[i]);
        end
        run <= 1'b0;
    endtask

    task automatic reset_and_port_test();
        begin_test();
        prog_q.push_back(encode(OP_MOVI, 4'd3, 4'd0, next_operand()));
        prog_q.push_back(encode(OP_NOP, 4'd0, 4'd0, 12'h000));
        prog_q.push_back(encode(OP_HALT, 4'd0, 4'd0, 12'h000));
        load_program();
        run_program("reset_and_port", 10);
    endtask

    task automatic alu_test();
        begin_test();
        prog_q.push_back(encode(OP_MOVI, 4'd1, 4'd0, next_operand()));
        prog_q.push_back(encode(OP_MOVI, 4'd2, 4'd0, next_operand()));
        prog_q.push_back(encode(OP_ADD, 4'd3, 4'd1, {4'd2, 8'h00}));
        prog_q.push_back(encode(OP_SUB, 4'd4, 4'd1, {4'd2, 8'h00}));
        prog_q.push_back(encode(OP_AND, 4'd5, 4'd1, {4'd2, 8'h00}));
        prog_q.push_back(encode(OP_OR, 4'd6, 4'd1, {4'd2, 8'h00}));
        prog_q.push_back(encode(OP_XOR, 4'd7, 4'd1, {4'd2, 8'h00}));
        // Negate r1 and double it so the sum wraps past 2^24
        prog_q.push_back(encode(OP_SUB, 4'd8, 4'd0, {4'd1, 8'h00}));
        prog_q.push_back(encode(OP_ADD, 4'd9, 4'd8, {4'd8, 8'h00}));
        prog_q.push_back(encode(OP_XOR, 4'd10, 4'd8, {4'd4, 8'h00}));
        prog_q.push_back(encode(OP_HALT, 4'd0, 4'd0, 12'h000));
        load_program();
        run_program("alu_ops", 10);
    endtask

    task automatic back_pressure_test();
        begin_test();
        for (int i = 0; i < BP_WORDS; i++) begin
            prog_q.push_back(encode(OP_MOVI, 4'(i), 4'd0, next_operand()));
        end
        prog_q.push_back(encode(OP_HALT, 4'd0, 4'd0, 12'h000));
        load_program();
        run_program("back_pressure", 10);
    endtask

    task automatic branch_test();
        begin_test();
        prog_q.push_back(encode(OP_MOVI, 4'd1, 4'd0, 12'h001));
        prog_q.push_back(encode(OP_BNZ, 4'd0, 4'd1, 12'h005));
        prog_q.push_back(encode(OP_MOVI, 4'd2, 4'd0, 12'h111));
        prog_q.push_back(encode(OP_MOVI, 4'd3, 4'd0, 12'h222));
        prog_q.push_back(encode(OP_HALT, 4'd0, 4'd0, 12'h000));
        prog_q.push_back(encode(OP_MOVI, 4'd4, 4'd0, next_operand()));
        // r0 stays zero, so this one falls through
        prog_q.push_back(encode(OP_BNZ, 4'd0, 4'd0, 12'h009));
        prog_q.push_back(encode(OP_MOVI, 4'd5, 4'd0, next_operand()));
        prog_q.push_back(encode(OP_HALT, 4'd0, 4'd0, 12'h000));
        prog_q.push_back(encode(OP_MOVI, 4'd6, 4'd0, 12'h555));
        prog_q.push_back(encode(OP_HALT, 4'd0, 4'd0, 12'h000));
        load_program();
        run_program("branches", 10);
    endtask

    task automatic loop_halt_test();
        logic [11:0] n;
        begin_test();
        n = next_operand();
        n = 12'd3 + {9'd0, n[2:0]};
        prog_q.push_back(encode(OP_MOVI, 4'd1, 4'd0, n));
        prog_q.push_back(encode(OP_MOVI, 4'd2, 4'd0, 12'h001));
        prog_q.push_back(encode(OP_MOVI, 4'd3, 4'd0, 12'h000));
        prog_q.push_back(encode(OP_ADD, 4'd3, 4'd3, {4'd1, 8'h00}));
        prog_q.push_back(encode(OP_SUB, 4'd1, 4'd1, {4'd2, 8'h00}));
        prog_q.push_back(encode(OP_BNZ, 4'd0, 4'd1, 12'h003));
        prog_q.push_back(encode(OP_HALT, 4'd0, 4'd0, 12'h000));
        // Fetched behind HALT but must never retire
        prog_q.push_back(encode(OP_MOVI, 4'd4, 4'd0, 12'h0aa));
        load_program();
        run_program("loop_halt", 50);
    endtask

    initial begin
        iw_rst    <= 1'b1;
        run       <= 1'b0;
        prog_cyc  <= 1'b0;
        prog_stb  <= 1'b0;
        prog_we   <= 1'b0;
        prog_adr  <= '0;
        prog_dat  <= '0;
        lcg_state = 32'd1843;
        for (int i = 0; i < `CORE_MEM_WORDS; i++) begin
            image[i] = '0;
        end
        reset_and_port_test();
        alu_test();
        back_pressure_test();
        branch_test();
        loop_halt_test();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire
